//--- design/ctrl_pkg.sv
package ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Data and PC width
    localparam int xlen       = 32;
    // Register file address
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 7;
    // Packed immediate handed to the datapath
    localparam int imm_w      = 20;

    ////////////////////////////////////////////////////////////
    // RV32I base opcodes
    ////////////////////////////////////////////////////////////

    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] op_auipc  = 7'b0010111;
    localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] op_store  = 7'b0100011;
    localparam logic [opcode_w-1:0] op_op_imm = 7'b0010011;
    localparam logic [opcode_w-1:0] op_op     = 7'b0110011;

    // Instruction word seen through its encoding formats
    // B and J immediates are pulled out of the s and u views
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [opcode_w-1:0]   opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [opcode_w-1:0]   opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [opcode_w-1:0]   opcode;
        } s;
        struct packed {
            logic [19:0]           imm20;
            logic [reg_addr_w-1:0] rd;
            logic [opcode_w-1:0]   opcode;
        } u;
    } inst_t;

    // ADDI x0, x0, 0
    localparam inst_t nop_inst = 32'h0000_0013;

    ////////////////////////////////////////////////////////////
    // Opcode classes
    ////////////////////////////////////////////////////////////

    // Everything but LUI, AUIPC and JAL reads rs1
    function automatic logic uses_rs1(input logic [opcode_w-1:0] op);
        case (op)
            op_jalr, op_branch, op_load, op_store, op_op_imm, op_op: uses_rs1 = 1'b1;
            default: uses_rs1 = 1'b0;
        endcase
    endfunction

    // Only compare, store and reg-reg ops read rs2
    function automatic logic uses_rs2(input logic [opcode_w-1:0] op);
        case (op)
            op_branch, op_store, op_op: uses_rs2 = 1'b1;
            default: uses_rs2 = 1'b0;
        endcase
    endfunction

    // Branch and store leave the register file alone
    function automatic logic writes_rd(input logic [opcode_w-1:0] op);
        case (op)
            op_lui, op_auipc, op_jal, op_jalr, op_load, op_op_imm, op_op: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    endfunction

endpackage

//--- design/inst_pipe.sv
`timescale 1ns/100ps

module inst_pipe (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      freeze,
    input  ctrl_pkg::inst_t           entry,
    input  logic [ctrl_pkg::xlen-1:0] pc,
    output ctrl_pkg::inst_t           slot0,
    output ctrl_pkg::inst_t           slot1,
    output ctrl_pkg::inst_t           slot2,
    output ctrl_pkg::inst_t           slot3,
    output ctrl_pkg::inst_t           slot4,
    output logic [ctrl_pkg::xlen-1:0] slot2_pc
);

    // Fetch, read, execute, memory, write-back
    localparam int depth    = 5;
    // PC only travels as far as execute
    localparam int pc_depth = 3;

    ctrl_pkg::inst_t           slot_q [depth];
    logic [ctrl_pkg::xlen-1:0] pc_q   [pc_depth];

    ////////////////////////////////////////////////////////////
    // Shift chain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Empty pipe is all bubbles
            for (int i = 0; i < depth; i++)
            begin
                slot_q[i] <= ctrl_pkg::nop_inst;
            end
            for (int i = 0; i < pc_depth; i++)
            begin
                pc_q[i] <= '0;
            end
        end
        else if (!freeze)
        begin
            // Slot 0 takes the fetched word or the bubble
            slot_q[0] <= entry;
            pc_q[0]   <= pc;
            for (int i = 1; i < depth; i++)
            begin
                slot_q[i] <= slot_q[i-1];
            end
            for (int i = 1; i < pc_depth; i++)
            begin
                pc_q[i] <= pc_q[i-1];
            end
        end
    end

    // Slot taps
    assign slot0    = slot_q[0];
    assign slot1    = slot_q[1];
    assign slot2    = slot_q[2];
    assign slot3    = slot_q[3];
    assign slot4    = slot_q[4];
    assign slot2_pc = pc_q[2];

endmodule

//--- design/fetch_seq.sv
`timescale 1ns/100ps

module fetch_seq #(
    parameter logic [ctrl_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      freeze,
    input  ctrl_pkg::inst_t           inst,
    input  ctrl_pkg::inst_t           slot0,
    output logic [ctrl_pkg::xlen-1:0] pc,
    output ctrl_pkg::inst_t           entry,
    output logic                      stall
);

    localparam logic [ctrl_pkg::xlen-1:0] pc_step = 4;

    logic                            slot0_load;
    logic [ctrl_pkg::reg_addr_w-1:0] load_rd;
    logic                            rs1_hit;
    logic                            rs2_hit;

    ////////////////////////////////////////////////////////////
    // Load-use hazard
    ////////////////////////////////////////////////////////////

    // Load sitting in slot 0, its data is not ready for the word now fetched
    assign slot0_load = (slot0.r.opcode == ctrl_pkg::op_load);
    assign load_rd    = slot0.r.rd;

    // Only sources the fetched opcode really reads count
    assign rs1_hit = ctrl_pkg::uses_rs1(inst.r.opcode) && (inst.r.rs1 == load_rd);
    assign rs2_hit = ctrl_pkg::uses_rs2(inst.r.opcode) && (inst.r.rs2 == load_rd);

    // Load into x0 never needs a wait
    assign stall = slot0_load && (load_rd != '0) && (rs1_hit || rs2_hit);

    // Bubble goes in, the same word is fetched again next cycle
    assign entry = stall ? ctrl_pkg::nop_inst : inst;

    ////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= reset_pc;
        end
        else if (!freeze && !stall)
        begin
            // No redirects, always sequential
            pc <= pc + pc_step;
        end
    end

    // Bubble in slot 0 blocks a second stall on the retried word
    stall_once_a : assert property (@(posedge clk) disable iff (rst)
        (stall && !freeze) |=> !stall);

endmodule

//--- design/fwd_unit.sv
`timescale 1ns/100ps

module fwd_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            freeze,
    input  ctrl_pkg::inst_t slot2,
    input  ctrl_pkg::inst_t slot3,
    input  ctrl_pkg::inst_t slot4,
    output logic [1:0]      fwd_sel1,
    output logic [1:0]      fwd_sel2
);

    // 1 takes the memory-stage result, 2 the write-back result, 0 the register file
    function automatic logic [1:0] sel_code(
        input logic [ctrl_pkg::reg_addr_w-1:0] src,
        input logic [ctrl_pkg::reg_addr_w-1:0] rd_mem,
        input logic [ctrl_pkg::reg_addr_w-1:0] rd_wb
    );
        if (src == '0)
        begin
            // x0 reads as zero, never forwarded
            sel_code = 2'd0;
        end
        else if (src == rd_mem)
        begin
            // Nearer producer wins
            sel_code = 2'd1;
        end
        else if (src == rd_wb)
        begin
            sel_code = 2'd2;
        end
        else
        begin
            sel_code = 2'd0;
        end
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fwd_sel1 <= 2'd0;
            fwd_sel2 <= 2'd0;
        end
        else if (!freeze)
        begin
            fwd_sel1 <= sel_code(slot2.r.rs1, slot3.r.rd, slot4.r.rd);
            fwd_sel2 <= sel_code(slot2.r.rs2, slot3.r.rd, slot4.r.rd);
        end
    end

    // Only three legal sources per operand
    sel_legal_a : assert property (@(posedge clk) disable iff (rst)
        (fwd_sel1 != 2'd3) && (fwd_sel2 != 2'd3));

endmodule

//--- design/stage_decode.sv
`timescale 1ns/100ps

module stage_decode (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            freeze,
    input  ctrl_pkg::inst_t                 slot1,
    input  ctrl_pkg::inst_t                 slot2,
    input  ctrl_pkg::inst_t                 slot3,
    input  ctrl_pkg::inst_t                 slot4,
    input  logic [ctrl_pkg::xlen-1:0]       slot2_pc,
    output logic [ctrl_pkg::reg_addr_w-1:0] reg_addr1,
    output logic [ctrl_pkg::reg_addr_w-1:0] reg_addr2,
    output logic                            reg_rd1,
    output logic                            reg_rd2,
    output logic [ctrl_pkg::opcode_w-1:0]   dp_op,
    output logic [2:0]                      dp_funct3,
    output logic [ctrl_pkg::imm_w-1:0]      dp_imm,
    output logic [ctrl_pkg::xlen-1:0]       dp_pc,
    output logic [ctrl_pkg::opcode_w-1:0]   mem_op,
    output logic [2:0]                      mem_funct3,
    output logic                            wb_en,
    output logic [ctrl_pkg::reg_addr_w-1:0] wb_addr
);

    // Immediate packed into 20 bits, datapath does the extension and shifting
    function automatic logic [ctrl_pkg::imm_w-1:0] imm_of(input ctrl_pkg::inst_t w);
        case (w.r.opcode)
            ctrl_pkg::op_lui, ctrl_pkg::op_auipc:
                imm_of = w.u.imm20;
            // J order: imm[20], imm[10:1], imm[11], imm[19:12] rearranged
            ctrl_pkg::op_jal:
                imm_of = {w.u.imm20[19], w.u.imm20[7:0], w.u.imm20[8], w.u.imm20[18:9]};
            ctrl_pkg::op_jalr, ctrl_pkg::op_load, ctrl_pkg::op_op_imm:
                imm_of = {8'd0, w.i.imm12};
            ctrl_pkg::op_store:
                imm_of = {8'd0, w.s.imm_hi, w.s.imm_lo};
            // B order: imm[12], imm[11], imm[10:5], imm[4:1]
            ctrl_pkg::op_branch:
                imm_of = {8'd0, w.s.imm_hi[6], w.s.imm_lo[0], w.s.imm_hi[5:0], w.s.imm_lo[4:1]};
            // funct7 picks SUB and SRA
            ctrl_pkg::op_op:
                imm_of = {13'd0, w.r.funct7};
            default:
                imm_of = '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Register read and execute banks
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Outputs show the bubble decode
            reg_addr1 <= ctrl_pkg::nop_inst.r.rs1;
            reg_addr2 <= ctrl_pkg::nop_inst.r.rs2;
            reg_rd1   <= ctrl_pkg::uses_rs1(ctrl_pkg::nop_inst.r.opcode);
            reg_rd2   <= ctrl_pkg::uses_rs2(ctrl_pkg::nop_inst.r.opcode);
            dp_op     <= ctrl_pkg::nop_inst.r.opcode;
            dp_funct3 <= ctrl_pkg::nop_inst.r.funct3;
            dp_imm    <= imm_of(ctrl_pkg::nop_inst);
            dp_pc     <= '0;
        end
        else if (!freeze)
        begin
            // Slot 1 drives the register file ports
            reg_addr1 <= slot1.r.rs1;
            reg_addr2 <= slot1.r.rs2;
            reg_rd1   <= ctrl_pkg::uses_rs1(slot1.r.opcode);
            reg_rd2   <= ctrl_pkg::uses_rs2(slot1.r.opcode);
            // Slot 2 drives the ALU
            dp_op     <= slot2.r.opcode;
            dp_funct3 <= slot2.r.funct3;
            dp_imm    <= imm_of(slot2);
            dp_pc     <= slot2_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory and write-back banks
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_op     <= ctrl_pkg::nop_inst.r.opcode;
            mem_funct3 <= ctrl_pkg::nop_inst.r.funct3;
            wb_en      <= ctrl_pkg::writes_rd(ctrl_pkg::nop_inst.r.opcode);
            wb_addr    <= ctrl_pkg::nop_inst.r.rd;
        end
        else if (!freeze)
        begin
            // funct3 gives access size and sign
            mem_op     <= slot3.r.opcode;
            mem_funct3 <= slot3.r.funct3;
            wb_en      <= ctrl_pkg::writes_rd(slot4.r.opcode);
            wb_addr    <= slot4.r.rd;
        end
    end

    // Write-back follows the memory stage by one advance
    wb_follows_mem_a : assert property (@(posedge clk) disable iff (rst)
        (wb_en && !$past(freeze) && !$past(freeze, 2))
            |-> ctrl_pkg::writes_rd($past(mem_op)));

endmodule

//--- design/pipe_ctrl.sv
`timescale 1ns/100ps

module pipe_ctrl #(
    parameter logic [ctrl_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  ctrl_pkg::inst_t                 inst,
    input  logic                            freeze,
    output logic [ctrl_pkg::xlen-1:0]       pc,
    output logic [ctrl_pkg::reg_addr_w-1:0] reg_addr1,
    output logic [ctrl_pkg::reg_addr_w-1:0] reg_addr2,
    output logic                            reg_rd1,
    output logic                            reg_rd2,
    output logic [1:0]                      fwd_sel1,
    output logic [1:0]                      fwd_sel2,
    output logic [ctrl_pkg::opcode_w-1:0]   dp_op,
    output logic [2:0]                      dp_funct3,
    output logic [ctrl_pkg::imm_w-1:0]      dp_imm,
    output logic [ctrl_pkg::xlen-1:0]       dp_pc,
    output logic [ctrl_pkg::opcode_w-1:0]   mem_op,
    output logic [2:0]                      mem_funct3,
    output logic                            wb_en,
    output logic [ctrl_pkg::reg_addr_w-1:0] wb_addr
);

    // Word entering slot 0
    ctrl_pkg::inst_t           entry;
    ctrl_pkg::inst_t           slot0;
    ctrl_pkg::inst_t           slot1;
    ctrl_pkg::inst_t           slot2;
    ctrl_pkg::inst_t           slot3;
    ctrl_pkg::inst_t           slot4;
    logic [ctrl_pkg::xlen-1:0] slot2_pc;

    ////////////////////////////////////////////////////////////
    // Fetch and slot chain
    ////////////////////////////////////////////////////////////

    fetch_seq #(
        .reset_pc (reset_pc)
    ) fetch_seq_i (
        .clk    (clk),
        .rst    (rst),
        .freeze (freeze),
        .inst   (inst),
        .slot0  (slot0),
        .pc     (pc),
        .entry  (entry),
        .stall  ()
    );

    inst_pipe inst_pipe_i (
        .clk      (clk),
        .rst      (rst),
        .freeze   (freeze),
        .entry    (entry),
        .pc       (pc),
        .slot0    (slot0),
        .slot1    (slot1),
        .slot2    (slot2),
        .slot3    (slot3),
        .slot4    (slot4),
        .slot2_pc (slot2_pc)
    );

    // Forwarding for the operands now in execute
    fwd_unit fwd_unit_i (
        .clk      (clk),
        .rst      (rst),
        .freeze   (freeze),
        .slot2    (slot2),
        .slot3    (slot3),
        .slot4    (slot4),
        .fwd_sel1 (fwd_sel1),
        .fwd_sel2 (fwd_sel2)
    );

    stage_decode stage_decode_i (
        .clk        (clk),
        .rst        (rst),
        .freeze     (freeze),
        .slot1      (slot1),
        .slot2      (slot2),
        .slot3      (slot3),
        .slot4      (slot4),
        .slot2_pc   (slot2_pc),
        .reg_addr1  (reg_addr1),
        .reg_addr2  (reg_addr2),
        .reg_rd1    (reg_rd1),
        .reg_rd2    (reg_rd2),
        .dp_op      (dp_op),
        .dp_funct3  (dp_funct3),
        .dp_imm     (dp_imm),
        .dp_pc      (dp_pc),
        .mem_op     (mem_op),
        .mem_funct3 (mem_funct3),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr)
    );

endmodule

//--- bench/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

////////////////////////////////////////////////////////////
// Shadow pipeline state
////////////////////////////////////////////////////////////

// Own PC, five instruction slots and the PCs of slots 0 to 2
logic [31:0] sh_pc;
logic [31:0] sh_slot [5];
logic [31:0] sh_spc  [3];

// Expected registered outputs
logic [4:0]  exp_reg_addr1;
logic [4:0]  exp_reg_addr2;
logic        exp_reg_rd1;
logic        exp_reg_rd2;
logic [1:0]  exp_fwd_sel1;
logic [1:0]  exp_fwd_sel2;
logic [6:0]  exp_dp_op;
logic [2:0]  exp_dp_funct3;
logic [19:0] exp_dp_imm;
logic [31:0] exp_dp_pc;
logic [6:0]  exp_mem_op;
logic [2:0]  exp_mem_funct3;
logic        exp_wb_en;
logic [4:0]  exp_wb_addr;

// Bits are {reads rs1, reads rs2, writes rd}
function automatic logic [2:0] op_class(input logic [6:0] op);
    case (op)
        ctrl_pkg::op_lui, ctrl_pkg::op_auipc, ctrl_pkg::op_jal:
            return 3'b001;
        ctrl_pkg::op_jalr, ctrl_pkg::op_load, ctrl_pkg::op_op_imm:
            return 3'b101;
        ctrl_pkg::op_branch, ctrl_pkg::op_store:
            return 3'b110;
        ctrl_pkg::op_op:
            return 3'b111;
        default:
            return 3'b000;
    endcase
endfunction

// Packed immediate straight from the raw bit positions of the word
function automatic logic [19:0] expected_imm(input logic [31:0] w);
    case (w[6:0])
        ctrl_pkg::op_lui, ctrl_pkg::op_auipc:
            return w[31:12];
        // imm[20:1]
        ctrl_pkg::op_jal:
            return {w[31], w[19:12], w[20], w[30:21]};
        ctrl_pkg::op_jalr, ctrl_pkg::op_load, ctrl_pkg::op_op_imm:
            return {8'd0, w[31:20]};
        ctrl_pkg::op_store:
            return {8'd0, w[31:25], w[11:7]};
        // imm[12:1]
        ctrl_pkg::op_branch:
            return {8'd0, w[31], w[7], w[30:25], w[11:8]};
        ctrl_pkg::op_op:
            return {13'd0, w[31:25]};
        default:
            return 20'd0;
    endcase
endfunction

// Memory-stage producer beats write-back, x0 never forwarded
function automatic logic [1:0] fwd_code(input logic [4:0] src, input logic [31:0] mem_w,
    input logic [31:0] wb_w);
    if (src != 5'd0 && src == mem_w[11:7])
    begin
        return 2'd1;
    end
    if (src != 5'd0 && src == wb_w[11:7])
    begin
        return 2'd2;
    end
    return 2'd0;
endfunction

// Load in slot 0 whose rd is read by the word being fetched
function automatic logic load_use(input logic [31:0] held, input logic [31:0] fetched);
    logic [2:0] cls;
    logic [4:0] rd;
    cls = op_class(fetched[6:0]);
    rd  = held[11:7];
    if (held[6:0] != ctrl_pkg::op_load || rd == 5'd0)
    begin
        return 1'b0;
    end
    return (cls[2] && fetched[19:15] == rd) || (cls[1] && fetched[24:20] == rd);
endfunction

////////////////////////////////////////////////////////////
// Stage banks and shadow step
////////////////////////////////////////////////////////////

// Next output values from the slots as they stand before the edge
function automatic void decode_banks();
    logic [2:0] rd_cls;
    logic [2:0] wb_cls;
    rd_cls         = op_class(sh_slot[1][6:0]);
    wb_cls         = op_class(sh_slot[4][6:0]);
    exp_reg_addr1  = sh_slot[1][19:15];
    exp_reg_addr2  = sh_slot[1][24:20];
    exp_reg_rd1    = rd_cls[2];
    exp_reg_rd2    = rd_cls[1];
    exp_fwd_sel1   = fwd_code(sh_slot[2][19:15], sh_slot[3], sh_slot[4]);
    exp_fwd_sel2   = fwd_code(sh_slot[2][24:20], sh_slot[3], sh_slot[4]);
    exp_dp_op      = sh_slot[2][6:0];
    exp_dp_funct3  = sh_slot[2][14:12];
    exp_dp_imm     = expected_imm(sh_slot[2]);
    exp_dp_pc      = sh_spc[2];
    exp_mem_op     = sh_slot[3][6:0];
    exp_mem_funct3 = sh_slot[3][14:12];
    exp_wb_en      = wb_cls[0];
    exp_wb_addr    = sh_slot[4][11:7];
endfunction

// Empty pipe of bubbles, outputs show the bubble decode
function automatic void reset_shadow(input logic [31:0] start);
    sh_pc = start;
    for (int i = 0; i < 5; i++)
    begin
        sh_slot[i] = ctrl_pkg::nop_inst;
    end
    for (int i = 0; i < 3; i++)
    begin
        sh_spc[i] = 32'd0;
    end
    decode_banks();
endfunction

// One unfrozen edge
function automatic void step_shadow(input logic [31:0] fetched);
    logic stall;
    decode_banks();
    stall = load_use(sh_slot[0], fetched);
    for (int i = 4; i > 0; i--)
    begin
        sh_slot[i] = sh_slot[i-1];
    end
    sh_spc[2]  = sh_spc[1];
    sh_spc[1]  = sh_spc[0];
    sh_spc[0]  = sh_pc;
    // Bubble in, same word fetched again
    sh_slot[0] = stall ? ctrl_pkg::nop_inst : fetched;
    if (!stall)
    begin
        sh_pc = sh_pc + 32'd4;
    end
endfunction

`endif

//--- bench/tb_pipe_ctrl.sv
`timescale 1ns/100ps

module tb_pipe_ctrl;

    localparam logic [31:0] start_pc   = 32'h0000_0100;
    localparam int          clk_period = 40;
    localparam int          reset_len  = 4;
    localparam int          n_cycles   = 400;
    // Words indexed by (pc - start_pc) / 4
    localparam int          mem_words  = 512;

    logic                            clk = 1'b0;
    logic                            rst;
    logic                            freeze;
    ctrl_pkg::inst_t                 inst;
    logic [ctrl_pkg::xlen-1:0]       pc;
    logic [ctrl_pkg::reg_addr_w-1:0] reg_addr1;
    logic [ctrl_pkg::reg_addr_w-1:0] reg_addr2;
    logic                            reg_rd1;
    logic                            reg_rd2;
    logic [1:0]                      fwd_sel1;
    logic [1:0]                      fwd_sel2;
    logic [ctrl_pkg::opcode_w-1:0]   dp_op;
    logic [2:0]                      dp_funct3;
    logic [ctrl_pkg::imm_w-1:0]      dp_imm;
    logic [ctrl_pkg::xlen-1:0]       dp_pc;
    logic [ctrl_pkg::opcode_w-1:0]   mem_op;
    logic [2:0]                      mem_funct3;
    logic                            wb_en;
    logic [ctrl_pkg::reg_addr_w-1:0] wb_addr;

    logic [31:0] imem [mem_words];
    int          seed        = 11;
    int          freeze_left = 0;
    int          errors      = 0;
    int          checks      = 0;

    `include "tb_ref.svh"

    pipe_ctrl #(
        .reset_pc (start_pc)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .freeze     (freeze),
        .pc         (pc),
        .reg_addr1  (reg_addr1),
        .reg_addr2  (reg_addr2),
        .reg_rd1    (reg_rd1),
        .reg_rd2    (reg_rd2),
        .fwd_sel1   (fwd_sel1),
        .fwd_sel2   (fwd_sel2),
        .dp_op      (dp_op),
        .dp_funct3  (dp_funct3),
        .dp_imm     (dp_imm),
        .dp_pc      (dp_pc),
        .mem_op     (mem_op),
        .mem_funct3 (mem_funct3),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Instruction memory
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    // Any of the nine opcodes with registers kept in x0..x7 so hazards come often
    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        logic [31:0] pick;
        w        = $random(seed);
        pick     = {$random(seed)} % 9;
        w[11:10] = 2'b00;
        w[19:18] = 2'b00;
        w[24:23] = 2'b00;
        case (pick)
            0: w[6:0] = ctrl_pkg::op_lui;
            1: w[6:0] = ctrl_pkg::op_auipc;
            2: w[6:0] = ctrl_pkg::op_jal;
            3: w[6:0] = ctrl_pkg::op_jalr;
            4: w[6:0] = ctrl_pkg::op_branch;
            5: w[6:0] = ctrl_pkg::op_load;
            6: w[6:0] = ctrl_pkg::op_store;
            7: w[6:0] = ctrl_pkg::op_op_imm;
            default: w[6:0] = ctrl_pkg::op_op;
        endcase
        return w;
    endfunction

    task automatic load_program();
        for (int i = 0; i < mem_words; i++)
        begin
            imem[i[8:0]] = random_inst();
        end
        // ALU chain with forwarding at distance one and two and an x0 source
        imem[0]  = i_word(12'd5, 5'd0, 3'd0, 5'd1, ctrl_pkg::op_op_imm);
        imem[1]  = i_word(12'd7, 5'd0, 3'd0, 5'd2, ctrl_pkg::op_op_imm);
        imem[2]  = r_word(7'd0, 5'd2, 5'd1, 3'd0, 5'd3, ctrl_pkg::op_op);
        imem[3]  = r_word(7'd0, 5'd3, 5'd3, 3'd0, 5'd4, ctrl_pkg::op_op);
        imem[4]  = r_word(7'h20, 5'd4, 5'd0, 3'd0, 5'd5, ctrl_pkg::op_op);
        // Load then dependent add gives one bubble
        imem[5]  = i_word(12'd0, 5'd1, 3'd2, 5'd6, ctrl_pkg::op_load);
        imem[6]  = r_word(7'd0, 5'd2, 5'd6, 3'd0, 5'd7, ctrl_pkg::op_op);
        // Independent add hides the load from the store
        imem[7]  = i_word(12'd4, 5'd1, 3'd2, 5'd8, ctrl_pkg::op_load);
        imem[8]  = r_word(7'd0, 5'd2, 5'd1, 3'd0, 5'd9, ctrl_pkg::op_op);
        imem[9]  = s_word(12'd8, 5'd8, 5'd1, 3'd2, ctrl_pkg::op_store);
        // Upper-immediate and control-flow formats while pc still steps by 4
        imem[10] = {20'h12345, 5'd10, ctrl_pkg::op_lui};
        imem[11] = {20'habcde, 5'd11, ctrl_pkg::op_auipc};
        imem[12] = s_word(12'h8a4, 5'd11, 5'd10, 3'd1, ctrl_pkg::op_branch);
        imem[13] = {20'h9f3c1, 5'd1, ctrl_pkg::op_jal};
        imem[14] = i_word(12'h7f0, 5'd1, 3'd0, 5'd0, ctrl_pkg::op_jalr);
        // Load into x0 never stalls
        imem[15] = i_word(12'd0, 5'd1, 3'd2, 5'd0, ctrl_pkg::op_load);
        imem[16] = r_word(7'd0, 5'd0, 5'd0, 3'd0, 5'd12, ctrl_pkg::op_op);
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - start_pc) >> 2;
        return imem[idx[8:0]];
    endfunction

    // Freeze pulses of 1 to 4 cycles once the fixed code has drained
    function automatic logic next_freeze(input int cycle);
        logic [31:0] r;
        if (cycle < 60)
        begin
            return 1'b0;
        end
        if (freeze_left > 0)
        begin
            freeze_left--;
            return 1'b1;
        end
        r = $random(seed);
        if (r[3:0] < 4'd2)
        begin
            freeze_left = int'(r[5:4]);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial
    begin
        rst    = 1'b1;
        freeze = 1'b0;
        inst   = ctrl_pkg::nop_inst;
        load_program();
        repeat (reset_len) @(posedge clk);
        #1;
        rst  = 1'b0;
        inst = fetch_word(pc);
        for (int c = 0; c < n_cycles; c++)
        begin
            @(posedge clk);
            #1;
            freeze = next_freeze(c);
            inst   = fetch_word(pc);
        end
        // Let the last compare run
        @(negedge clk);
        #1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Shadow steps on the inputs held since the previous edge
    always @(posedge clk)
    begin
        if (rst)
        begin
            reset_shadow(start_pc);
        end
        else if (!freeze)
        begin
            step_shadow(inst);
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare and watchdog
    ////////////////////////////////////////////////////////////

    task automatic check_field(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        checks++;
        field_a : assert (actual === expected)
        else
        begin
            errors++;
            $display("Error: %s expected %h, got %h", name, expected, actual);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            check_field("pc", sh_pc, pc);
            check_field("reg_addr1", 32'(exp_reg_addr1), 32'(reg_addr1));
            check_field("reg_addr2", 32'(exp_reg_addr2), 32'(reg_addr2));
            check_field("reg_rd1", 32'(exp_reg_rd1), 32'(reg_rd1));
            check_field("reg_rd2", 32'(exp_reg_rd2), 32'(reg_rd2));
            check_field("fwd_sel1", 32'(exp_fwd_sel1), 32'(fwd_sel1));
            check_field("fwd_sel2", 32'(exp_fwd_sel2), 32'(fwd_sel2));
            check_field("dp_op", 32'(exp_dp_op), 32'(dp_op));
            check_field("dp_funct3", 32'(exp_dp_funct3), 32'(dp_funct3));
            check_field("dp_imm", 32'(exp_dp_imm), 32'(dp_imm));
            check_field("dp_pc", exp_dp_pc, dp_pc);
            check_field("mem_op", 32'(exp_mem_op), 32'(mem_op));
            check_field("mem_funct3", 32'(exp_mem_funct3), 32'(mem_funct3));
            check_field("wb_en", 32'(exp_wb_en), 32'(wb_en));
            check_field("wb_addr", 32'(exp_wb_addr), 32'(wb_addr));
        end
    end

    initial
    begin
        #((reset_len + n_cycles + 20) * clk_period);
        $display("Timeout: the test sequence did not complete in time");
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- src.f
+incdir+bench
design/ctrl_pkg.sv
design/inst_pipe.sv
design/fetch_seq.sv
design/fwd_unit.sv
design/stage_decode.sv
design/pipe_ctrl.sv
bench/tb_pipe_ctrl.sv

//--- Makefile
# Verilator build and run for the pipeline control unit

VERILATOR ?= verilator
TOP       ?= tb_pipe_ctrl
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(wildcard design/*.sv bench/*.sv bench/*.svh)
FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: no verdict in $(LOG)"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
